// File: Makefile
VERILATOR ?= verilator
TOP       ?= aim_predictor_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: sim clean

# build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$($(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: source/aim_predictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module aim_predictor #(
    parameter int h_width    = `BP_H_WIDTH,
    parameter int k_width    = `BP_K_WIDTH,
    parameter int bh_width   = `BP_BH_WIDTH,
    parameter int addr_width = `BP_ADDR_WIDTH,
    parameter int gh_width   = `BP_GH_WIDTH
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          stall,
    // fetch
    input  wire [addr_width-1:0]         pc,
    input  wire [gh_width-1:0]           gh,
    input  wire [addr_width-1:0]         pc_reg,
    input  wire [bh_width-1:0]           bh_reg,
    input  wire bp_kind_pkg::kind_t      kind_pdc,
    output logic                         taken_pdc,
    output bp_hist_pkg::ctr2_t           taken_pdch_b,
    output bp_hist_pkg::ctr2_t           taken_pdch_g,
    output logic [`BP_PDCH_WIDTH-1:0]    tage_pdch,
    // execute
    input  wire                          update_en,
    input  wire [addr_width-1:0]         pc_ex,
    input  wire [bh_width-1:0]           bh_ex,
    input  wire [gh_width-1:0]           gh_ex,
    input  wire bp_kind_pkg::kind_t      kind_ex,
    input  wire                          taken_real,
    input  wire bp_hist_pkg::ctr2_t      taken_pdch_ex_b,
    input  wire [`BP_PDCH_WIDTH-1:0]     tage_pdch_ex,
    input  wire                          taken_pdc_ex
);

    logic train;
    logic taken_b;
    logic taken_g;

    // only conditional branches teach the tables
    assign train = update_en && (kind_ex == bp_kind_pkg::DIRECT_JUMP);

    bpht #(
        .h_width    (h_width),
        .bh_width   (bh_width),
        .addr_width (addr_width)
    ) u_bpht (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .pc         (pc_reg),
        .bh         (bh_reg),
        .update_en  (train),
        .pc_update  (pc_ex),
        .bh_update  (bh_ex),
        .taken_real (taken_real),
        .taken_pdc  (taken_b)
    );

    bpht_cache #(
        .k_width         (k_width),
        .addr_width      (addr_width)
    ) u_bpht_cache (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall           (stall),
        .pc              (pc_reg),
        .bh              (bh_reg[`BP_CACHE_BH-1:0]),
        .update_en       (train),
        .pc_update       (pc_ex),
        .bh_update       (bh_ex[`BP_CACHE_BH-1:0]),
        .taken_real      (taken_real),
        .taken_pdch_ex_b (taken_pdch_ex_b),
        .taken_pdch_b    (taken_pdch_b)
    );

    tage #(
        .h_width      (h_width),
        .gh_width     (gh_width),
        .addr_width   (addr_width)
    ) u_tage (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .update_en    (train),
        .pc           (pc),
        .gh           (gh),
        .pc_ex        (pc_ex),
        .gh_ex        (gh_ex),
        .taken_ex     (taken_real),
        .taken_pdc_ex (taken_pdc_ex),
        .pdch_ex      (tage_pdch_ex),
        .taken_pdc    (taken_g),
        .pdch         (tage_pdch)
    );

    assign taken_pdch_g = {taken_g, 1'b0};

    // bit 2 kinds always jump, direct jumps ask the bpht
    assign taken_pdc = kind_pdc[2] | (kind_pdc[0] & taken_b);

endmodule

`default_nettype wire

// File: source/bp_hist_pkg.sv
`default_nettype none

`include "bp_params.svh"

package bp_hist_pkg;

    // msb set predicts taken
    typedef logic [1:0] ctr2_t;
    typedef logic [2:0] ctr3_t;

    localparam ctr2_t CTR2_WEAK_NT = 2'b01;

    // prediction history of tage, carried down the pipe
    typedef struct packed {
        logic                    hit;
        ctr2_t                   base_ctr;
        ctr3_t                   tag_ctr;
        logic [`BP_TAGE_TAG-1:0] tag;
    } tage_pdch_t;

    function automatic ctr2_t sat2_next(input ctr2_t c, input logic taken);
        if (taken) begin
            return (c == 2'b11) ? c : c + 2'd1;
        end
        return (c == 2'b00) ? c : c - 2'd1;
    endfunction

    function automatic ctr3_t sat3_next(input ctr3_t c, input logic taken);
        if (taken) begin
            return (c == 3'b111) ? c : c + 3'd1;
        end
        return (c == 3'b000) ? c : c - 3'd1;
    endfunction

endpackage

`default_nettype wire

// File: source/bp_kind_pkg.sv
`default_nettype none

package bp_kind_pkg;

    // branch kind from decode
    // bit 2 set means always taken, bit 0 marks a direction to predict
    typedef logic [2:0] kind_t;

    localparam kind_t NOT_JUMP      = 3'd0;
    localparam kind_t DIRECT_JUMP   = 3'd1;

    localparam kind_t RET           = 3'd4;
    localparam kind_t INDIRECT_JUMP = 3'd5;
    localparam kind_t CALL          = 3'd6;
    localparam kind_t JUMP          = 3'd7;

endpackage

`default_nettype wire

// File: source/bp_params.svh
`ifndef BP_PARAMS_SVH
`define BP_PARAMS_SVH

// index bits of bpht and tage, 256 entries
`define BP_H_WIDTH 8

// tag bits kept by the local-history cache
`define BP_K_WIDTH 12

// history widths owned by the core
`define BP_BH_WIDTH 16
`define BP_GH_WIDTH 32

// word address of the fetch pc
`define BP_ADDR_WIDTH 30

// low bh bits that select a cache entry
`define BP_CACHE_BH 4

`define BP_TAGE_TAG 6
`define BP_PDCH_WIDTH 12

`endif

// File: source/bpht.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module bpht #(
    parameter int h_width    = `BP_H_WIDTH,
    parameter int bh_width   = `BP_BH_WIDTH,
    parameter int addr_width = `BP_ADDR_WIDTH
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  stall,
    input  wire [addr_width-1:0] pc,
    input  wire [bh_width-1:0]   bh,
    input  wire                  update_en,
    input  wire [addr_width-1:0] pc_update,
    input  wire [bh_width-1:0]   bh_update,
    input  wire                  taken_real,
    output logic                 taken_pdc
);

    localparam int depth = 1 << h_width;

    bp_hist_pkg::ctr2_t pht [depth];

    logic [h_width-1:0] rd_idx;
    logic [h_width-1:0] wr_idx;

    // pc xor local history, gshare style but per branch
    assign rd_idx = pc[h_width-1:0] ^ bh[h_width-1:0];
    assign wr_idx = pc_update[h_width-1:0] ^ bh_update[h_width-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                pht[i] <= bp_hist_pkg::CTR2_WEAK_NT;
            end
            taken_pdc <= 1'b0;
        end else begin
            // hold the prediction while fetch is stalled
            if (!stall) begin
                taken_pdc <= pht[rd_idx][1];
            end
            if (update_en) begin
                pht[wr_idx] <= bp_hist_pkg::sat2_next(pht[wr_idx], taken_real);
            end
        end
    end

endmodule

`default_nettype wire

// File: source/bpht_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module bpht_cache #(
    parameter int k_width    = `BP_K_WIDTH,
    parameter int addr_width = `BP_ADDR_WIDTH
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      stall,
    input  wire [addr_width-1:0]     pc,
    input  wire [`BP_CACHE_BH-1:0]   bh,
    input  wire                      update_en,
    input  wire [addr_width-1:0]     pc_update,
    input  wire [`BP_CACHE_BH-1:0]   bh_update,
    input  wire                      taken_real,
    input  wire bp_hist_pkg::ctr2_t  taken_pdch_ex_b,
    output bp_hist_pkg::ctr2_t       taken_pdch_b
);

    localparam int entries = 1 << `BP_CACHE_BH;

    logic               valid [entries];
    logic [k_width-1:0] tag   [entries];
    bp_hist_pkg::ctr2_t ctr   [entries];

    logic rd_hit;
    logic wr_hit;

    assign rd_hit = valid[bh] && (tag[bh] == pc[k_width-1:0]);
    assign wr_hit = valid[bh_update] && (tag[bh_update] == pc_update[k_width-1:0]);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < entries; i++) begin
                valid[i] <= 1'b0;
                ctr[i]   <= bp_hist_pkg::CTR2_WEAK_NT;
            end
            taken_pdch_b <= bp_hist_pkg::CTR2_WEAK_NT;
        end else begin
            if (!stall) begin
                taken_pdch_b <= rd_hit ? ctr[bh] : bp_hist_pkg::CTR2_WEAK_NT;
            end
            if (update_en) begin
                if (wr_hit) begin
                    // counter as seen at fetch, not the current entry
                    ctr[bh_update] <= bp_hist_pkg::sat2_next(taken_pdch_ex_b, taken_real);
                end else begin
                    // miss, take over the slot
                    valid[bh_update] <= 1'b1;
                    tag[bh_update]   <= pc_update[k_width-1:0];
                    ctr[bh_update]   <= taken_real ? 2'b10 : 2'b01;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/tage.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module tage #(
    parameter int h_width    = `BP_H_WIDTH,
    parameter int gh_width   = `BP_GH_WIDTH,
    parameter int addr_width = `BP_ADDR_WIDTH
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          stall,
    input  wire                          update_en,
    input  wire [addr_width-1:0]         pc,
    input  wire [gh_width-1:0]           gh,
    input  wire [addr_width-1:0]         pc_ex,
    input  wire [gh_width-1:0]           gh_ex,
    input  wire                          taken_ex,
    input  wire                          taken_pdc_ex,
    input  wire bp_hist_pkg::tage_pdch_t pdch_ex,
    output logic                         taken_pdc,
    output bp_hist_pkg::tage_pdch_t      pdch
);

    localparam int depth = 1 << h_width;
    localparam int tag_w = `BP_TAGE_TAG;

    localparam bp_hist_pkg::ctr3_t ctr3_weak_nt = 3'b001;

    // base table, pc only
    bp_hist_pkg::ctr2_t base_ctr [depth];

    // tagged table, pc and folded global history
    logic               tag_valid [depth];
    logic [tag_w-1:0]   tag_tag   [depth];
    bp_hist_pkg::ctr3_t tag_ctr   [depth];

    logic [h_width-1:0] base_idx;
    logic [h_width-1:0] tag_idx;
    logic [tag_w-1:0]   look_tag;
    logic               look_hit;

    logic [h_width-1:0] upd_base_idx;
    logic [h_width-1:0] upd_tag_idx;
    logic               mispredict;

    // xor of the h_width slices of gh
    function automatic logic [h_width-1:0] fold_gh(input logic [gh_width-1:0] g);
        logic [h_width-1:0] f;
        f = '0;
        for (int s = 0; s < gh_width / h_width; s++) begin
            f = f ^ g[s*h_width +: h_width];
        end
        return f;
    endfunction

    assign base_idx = pc[h_width-1:0];
    assign tag_idx  = pc[h_width-1:0] ^ fold_gh(gh);
    // tag from the pc bits just above the index
    assign look_tag = pc[h_width +: tag_w];
    assign look_hit = tag_valid[tag_idx] && (tag_tag[tag_idx] == look_tag);

    assign upd_base_idx = pc_ex[h_width-1:0];
    assign upd_tag_idx  = pc_ex[h_width-1:0] ^ fold_gh(gh_ex);
    assign mispredict   = taken_pdc_ex != taken_ex;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                base_ctr[i]  <= bp_hist_pkg::CTR2_WEAK_NT;
                tag_valid[i] <= 1'b0;
                tag_ctr[i]   <= ctr3_weak_nt;
            end
            taken_pdc     <= 1'b0;
            pdch.hit      <= 1'b0;
            pdch.base_ctr <= bp_hist_pkg::CTR2_WEAK_NT;
            pdch.tag_ctr  <= ctr3_weak_nt;
            pdch.tag      <= '0;
        end else begin
            if (!stall) begin
                taken_pdc     <= look_hit ? tag_ctr[tag_idx][2] : base_ctr[base_idx][1];
                pdch.hit      <= look_hit;
                pdch.base_ctr <= base_ctr[base_idx];
                pdch.tag_ctr  <= tag_ctr[tag_idx];
                pdch.tag      <= look_tag;
            end
            if (update_en) begin
                // train whichever table gave the prediction
                if (pdch_ex.hit) begin
                    tag_ctr[upd_tag_idx] <= bp_hist_pkg::sat3_next(pdch_ex.tag_ctr, taken_ex);
                end else begin
                    base_ctr[upd_base_idx] <=
                        bp_hist_pkg::sat2_next(pdch_ex.base_ctr, taken_ex);
                end
                // a fresh weak entry overrides the saturated one on a hit
                if (mispredict) begin
                    tag_valid[upd_tag_idx] <= 1'b1;
                    tag_tag[upd_tag_idx]   <= pdch_ex.tag;
                    tag_ctr[upd_tag_idx]   <= taken_ex ? 3'd4 : 3'd3;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/bp_ref_model.svh
`ifndef BP_REF_MODEL_SVH
`define BP_REF_MODEL_SVH

localparam int m_depth = 1 << `BP_H_WIDTH;
localparam int m_lines = 1 << `BP_CACHE_BH;

// shadow tables of the three predictors
bp_hist_pkg::ctr2_t      m_pht    [m_depth];
logic                    m_cvalid [m_lines];
logic [`BP_K_WIDTH-1:0]  m_ctag   [m_lines];
bp_hist_pkg::ctr2_t      m_cctr   [m_lines];
bp_hist_pkg::ctr2_t      m_base   [m_depth];
logic                    m_tvalid [m_depth];
logic [`BP_TAGE_TAG-1:0] m_ttag   [m_depth];
bp_hist_pkg::ctr3_t      m_tctr   [m_depth];

function automatic bp_hist_pkg::ctr2_t bump2(input bp_hist_pkg::ctr2_t c, input logic up);
    if (up && c != 2'b11) return c + 2'd1;
    if (!up && c != 2'b00) return c - 2'd1;
    return c;
endfunction

function automatic bp_hist_pkg::ctr3_t bump3(input bp_hist_pkg::ctr3_t c, input logic up);
    if (up && c != 3'b111) return c + 3'd1;
    if (!up && c != 3'b000) return c - 3'd1;
    return c;
endfunction

// four 8-bit slices of gh xored together
function automatic logic [`BP_H_WIDTH-1:0] fold32(input logic [`BP_GH_WIDTH-1:0] g);
    return g[7:0] ^ g[15:8] ^ g[23:16] ^ g[31:24];
endfunction

function automatic void ref_reset();
    for (int i = 0; i < m_depth; i++) begin
        m_pht[i]    = 2'b01;
        m_base[i]   = 2'b01;
        m_tvalid[i] = 1'b0;
        m_tctr[i]   = 3'b001;
    end
    for (int i = 0; i < m_lines; i++) begin
        m_cvalid[i] = 1'b0;
        m_cctr[i]   = 2'b01;
    end
endfunction

function automatic logic ref_bpht_taken(input logic [29:0] p, input logic [15:0] b);
    return m_pht[p[7:0] ^ b[7:0]][1];
endfunction

function automatic bp_hist_pkg::ctr2_t ref_cache_ctr(input logic [29:0] p, input logic [15:0] b);
    if (m_cvalid[b[3:0]] && m_ctag[b[3:0]] == p[11:0]) return m_cctr[b[3:0]];
    return 2'b01;
endfunction

function automatic bp_hist_pkg::tage_pdch_t ref_tage_pdch(input logic [29:0] p,
                                                          input logic [31:0] g);
    bp_hist_pkg::tage_pdch_t d;
    logic [7:0] ti;
    ti         = p[7:0] ^ fold32(g);
    d.tag      = p[13:8];
    d.hit      = m_tvalid[ti] && (m_ttag[ti] == d.tag);
    d.base_ctr = m_base[p[7:0]];
    d.tag_ctr  = m_tctr[ti];
    return d;
endfunction

function automatic logic ref_tage_taken(input bp_hist_pkg::tage_pdch_t d);
    return d.hit ? d.tag_ctr[2] : d.base_ctr[1];
endfunction

function automatic void ref_train(input logic [29:0] p, input logic [15:0] b,
                                  input logic [31:0] g, input logic taken,
                                  input bp_hist_pkg::ctr2_t carry_b,
                                  input bp_hist_pkg::tage_pdch_t d, input logic guess);
    logic [7:0] ti;
    ti = p[7:0] ^ fold32(g);
    m_pht[p[7:0] ^ b[7:0]] = bump2(m_pht[p[7:0] ^ b[7:0]], taken);
    if (m_cvalid[b[3:0]] && m_ctag[b[3:0]] == p[11:0]) begin
        m_cctr[b[3:0]] = bump2(carry_b, taken);
    end else begin
        m_cvalid[b[3:0]] = 1'b1;
        m_ctag[b[3:0]]   = p[11:0];
        m_cctr[b[3:0]]   = taken ? 2'b10 : 2'b01;
    end
    if (d.hit) m_tctr[ti] = bump3(d.tag_ctr, taken);
    else m_base[p[7:0]] = bump2(d.base_ctr, taken);
    // wrong guess claims a tagged slot
    if (guess != taken) begin
        m_tvalid[ti] = 1'b1;
        m_ttag[ti]   = d.tag;
        m_tctr[ti]   = taken ? 3'd4 : 3'd3;
    end
endfunction

`endif

// File: tb/aim_predictor_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bp_params.svh"

module aim_predictor_tb;

    localparam int clk_period = 100;
    localparam int n_random   = 400;
    // reset, directed part, random mix and margin
    localparam int cycle_limit = 8 + 40 + n_random + 200;

    logic                      clk;
    logic                      rst_n;
    logic                      stall;
    logic [`BP_ADDR_WIDTH-1:0] pc;
    logic [`BP_GH_WIDTH-1:0]   gh;
    logic [`BP_ADDR_WIDTH-1:0] pc_reg;
    logic [`BP_BH_WIDTH-1:0]   bh_reg;
    bp_kind_pkg::kind_t        kind_pdc;
    logic                      taken_pdc;
    bp_hist_pkg::ctr2_t        taken_pdch_b;
    bp_hist_pkg::ctr2_t        taken_pdch_g;
    logic [`BP_PDCH_WIDTH-1:0] tage_pdch;
    logic                      update_en;
    logic [`BP_ADDR_WIDTH-1:0] pc_ex;
    logic [`BP_BH_WIDTH-1:0]   bh_ex;
    logic [`BP_GH_WIDTH-1:0]   gh_ex;
    bp_kind_pkg::kind_t        kind_ex;
    logic                      taken_real;
    bp_hist_pkg::ctr2_t        taken_pdch_ex_b;
    logic [`BP_PDCH_WIDTH-1:0] tage_pdch_ex;
    logic                      taken_pdc_ex;

    // what the dut registers should hold
    logic                    exp_b;
    logic                    exp_g;
    logic                    exp_pdc;
    bp_hist_pkg::ctr2_t      exp_cache;
    bp_hist_pkg::tage_pdch_t exp_pdch;

    int errors = 0;
    int checks = 0;
    int cycles = 0;
    logic [31:0] r;

    `include "bp_ref_model.svh"

    aim_predictor u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout, run did not finish within %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // model follows each edge and outputs are checked a quarter period later
    initial forever begin
        @(posedge clk);
        if (!rst_n) begin
            ref_reset();
            exp_b     = 1'b0;
            exp_g     = 1'b0;
            exp_cache = 2'b01;
            exp_pdch  = {1'b0, 2'b01, 3'b001, 6'd0};
        end else begin
            if (!stall) begin
                exp_b     = ref_bpht_taken(pc_reg, bh_reg);
                exp_cache = ref_cache_ctr(pc_reg, bh_reg);
                exp_pdch  = ref_tage_pdch(pc, gh);
                exp_g     = ref_tage_taken(exp_pdch);
            end
            if (update_en && kind_ex == bp_kind_pkg::DIRECT_JUMP) begin
                ref_train(pc_ex, bh_ex, gh_ex, taken_real, taken_pdch_ex_b,
                          tage_pdch_ex, taken_pdc_ex);
            end
        end
        #(clk_period / 4);
        exp_pdc = kind_pdc[2] | (kind_pdc[0] & exp_b);
        checks++;
        if (taken_pdc !== exp_pdc) begin
            errors++;
            $display("[ERROR] %0t taken_pdc expected %b actual %b", $time, exp_pdc, taken_pdc);
        end
        if (taken_pdch_b !== exp_cache) begin
            errors++;
            $display("[ERROR] %0t taken_pdch_b expected %b actual %b",
                     $time, exp_cache, taken_pdch_b);
        end
        if (taken_pdch_g !== {exp_g, 1'b0}) begin
            errors++;
            $display("[ERROR] %0t taken_pdch_g expected %b actual %b",
                     $time, {exp_g, 1'b0}, taken_pdch_g);
        end
        if (tage_pdch !== exp_pdch) begin
            errors++;
            $display("[ERROR] %0t tage_pdch expected %h actual %h", $time, exp_pdch, tage_pdch);
        end
    end

    task automatic look(input logic [29:0] p, input logic [15:0] b, input logic [31:0] g,
                        input bp_kind_pkg::kind_t kind);
        @(negedge clk);
        pc        = p;
        pc_reg    = p;
        bh_reg    = b;
        gh        = g;
        kind_pdc  = kind;
        update_en = 1'b0;
    endtask

    // resolve a branch with the histories a fetch of it would carry
    task automatic train(input logic [29:0] p, input logic [15:0] b, input logic [31:0] g,
                         input bp_kind_pkg::kind_t kind, input logic taken);
        bp_hist_pkg::tage_pdch_t d;
        look(p, b, g, kind);
        d               = ref_tage_pdch(p, g);
        pc_ex           = p;
        bh_ex           = b;
        gh_ex           = g;
        kind_ex         = kind;
        taken_real      = taken;
        taken_pdch_ex_b = ref_cache_ctr(p, b);
        tage_pdch_ex    = d;
        taken_pdc_ex    = ref_tage_taken(d);
        update_en       = 1'b1;
    endtask

    initial begin
        void'($urandom(32'hf4aa));
        rst_n           = 1'b0;
        stall           = 1'b0;
        pc              = '0;
        gh              = '0;
        pc_reg          = '0;
        bh_reg          = '0;
        kind_pdc        = bp_kind_pkg::NOT_JUMP;
        update_en       = 1'b0;
        pc_ex           = '0;
        bh_ex           = '0;
        gh_ex           = '0;
        kind_ex         = bp_kind_pkg::NOT_JUMP;
        taken_real      = 1'b0;
        taken_pdch_ex_b = 2'b01;
        tage_pdch_ex    = '0;
        taken_pdc_ex    = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // every kind on cold tables
        look(30'h123, 16'h42, 32'h0, bp_kind_pkg::NOT_JUMP);
        look(30'h123, 16'h42, 32'h0, bp_kind_pkg::DIRECT_JUMP);
        look(30'h123, 16'h42, 32'h0, bp_kind_pkg::RET);
        look(30'h123, 16'h42, 32'h0, bp_kind_pkg::INDIRECT_JUMP);
        look(30'h123, 16'h42, 32'h0, bp_kind_pkg::CALL);
        look(30'h123, 16'h42, 32'h0, bp_kind_pkg::JUMP);

        // calls do not train but direct jumps do
        train(30'h123, 16'h42, 32'h0, bp_kind_pkg::CALL, 1'b1);
        train(30'h123, 16'h42, 32'h0, bp_kind_pkg::CALL, 1'b1);
        look(30'h123, 16'h42, 32'h0, bp_kind_pkg::DIRECT_JUMP);
        train(30'h123, 16'h42, 32'h0, bp_kind_pkg::DIRECT_JUMP, 1'b1);
        train(30'h123, 16'h42, 32'h0, bp_kind_pkg::DIRECT_JUMP, 1'b1);
        look(30'h123, 16'h42, 32'h0, bp_kind_pkg::DIRECT_JUMP);
        look(30'h123, 16'h42, 32'h0, bp_kind_pkg::DIRECT_JUMP);

        // cache allocates and saturates before a conflicting pc takes the slot
        train(30'h456, 16'h5, 32'h0, bp_kind_pkg::DIRECT_JUMP, 1'b1);
        train(30'h456, 16'h5, 32'h0, bp_kind_pkg::DIRECT_JUMP, 1'b1);
        train(30'h456, 16'h5, 32'h0, bp_kind_pkg::DIRECT_JUMP, 1'b1);
        look(30'h456, 16'h5, 32'h0, bp_kind_pkg::DIRECT_JUMP);
        train(30'h456, 16'h5, 32'h0, bp_kind_pkg::DIRECT_JUMP, 1'b1);
        // older fetch that still saw the entry weak
        taken_pdch_ex_b = 2'b01;
        look(30'h456, 16'h5, 32'h0, bp_kind_pkg::DIRECT_JUMP);
        look(30'h789, 16'h15, 32'h0, bp_kind_pkg::DIRECT_JUMP);

        // tage mispredict allocates a tagged entry
        train(30'h2a10, 16'h0, 32'h1234_5678, bp_kind_pkg::DIRECT_JUMP, 1'b1);
        look(30'h2a10, 16'h0, 32'h1234_5678, bp_kind_pkg::DIRECT_JUMP);
        look(30'h2a10, 16'h0, 32'h1234_5678, bp_kind_pkg::DIRECT_JUMP);

        // frozen outputs while writes go on
        look(30'h3c0, 16'h7, 32'h55, bp_kind_pkg::DIRECT_JUMP);
        look(30'h3c0, 16'h7, 32'h55, bp_kind_pkg::DIRECT_JUMP);
        stall = 1'b1;
        train(30'h123, 16'h42, 32'h0, bp_kind_pkg::DIRECT_JUMP, 1'b0);
        train(30'h123, 16'h42, 32'h0, bp_kind_pkg::DIRECT_JUMP, 1'b0);
        train(30'h123, 16'h42, 32'h0, bp_kind_pkg::DIRECT_JUMP, 1'b0);
        look(30'h123, 16'h42, 32'h0, bp_kind_pkg::DIRECT_JUMP);
        stall = 1'b0;
        look(30'h123, 16'h42, 32'h0, bp_kind_pkg::DIRECT_JUMP);

        // small pc and history space so entries collide and hit
        for (int i = 0; i < n_random; i++) begin
            r = $urandom;
            if (r[3]) begin
                train({20'd0, r[17:16], 4'd0, r[21:18]}, {12'd0, r[25:22]}, {30'd0, r[27:26]},
                      r[15] ? bp_kind_pkg::DIRECT_JUMP : r[30:28], r[31]);
            end else begin
                look({20'd0, r[17:16], 4'd0, r[21:18]}, {12'd0, r[25:22]}, {30'd0, r[27:26]},
                     r[30:28]);
            end
            stall = (r[2:0] == 3'd0);
        end
        look(30'h0, 16'h0, 32'h0, bp_kind_pkg::NOT_JUMP);
        stall = 1'b0;
        repeat (2) @(negedge clk);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+source
+incdir+tb
source/bp_kind_pkg.sv
source/bp_hist_pkg.sv
source/bpht.sv
source/bpht_cache.sv
source/tage.sv
source/aim_predictor.sv
tb/aim_predictor_tb.sv
